// File: all.f
design/dacFramePkg.sv
design/dacCtrlPkg.sv
design/dacCommandBuilder.sv
design/dacWordFifo.sv
design/dacSpiSerializer.sv
design/dacLtc2624Model.sv
design/dacSubsystem.sv
verif/dacSubsystem_sva.sv
verif/dacSubsystemChecker.sv
verif/dacSubsystemTb.sv

// File: design/dacCommandBuilder.sv
`timescale 1ns/1ps

module dacCommandBuilder (
	input logic DAC_CLR,
	input logic reseted,
	input logic writeStrobe,
	input logic [3:0] writeAddress,
	input logic [3:0] writeCommand,
	input logic [11:0] writeValue,
	output logic busy,
	output logic push,
	output dacFramePkg::dacFrame pushFrame,
	input logic full
);

	// One frame waiting to enter the FIFO
	logic pending;
	dacFramePkg::dacFrame frameReg;

	// A strobe is taken only when nothing is held
	logic accept;

	assign accept = writeStrobe && !pending;

	//////////////////////////////
	// Pending flag
	//////////////////////////////

	// Set by an accepted strobe, cleared once the FIFO takes the frame
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			pending <= 1'b0;
		end else if (!pending) begin
			pending <= writeStrobe;
		end else if (!full) begin
			pending <= 1'b0;
		end
	end

	// Frame assembly from the host fields
	// Padding bits are forced to zero
	always_ff @(posedge DAC_CLR) begin
		if (accept) begin
			frameReg.fields.dontCareHi <= '0;
			frameReg.fields.command <= writeCommand;
			frameReg.fields.address <= writeAddress;
			frameReg.fields.value <= writeValue;
			frameReg.fields.dontCareLo <= '0;
		end
	end

	// Host must hold further writes while a frame waits
	assign busy = pending;

	// Push as soon as the FIFO has room
	assign push = pending && !full;
	assign pushFrame = frameReg;

endmodule

// File: design/dacCtrlPkg.sv
package dacCtrlPkg;

	//////////////////////////////
	// Default build constants
	//////////////////////////////

	// Frames the buffer can hold between builder and serializer
	localparam int defFifoDepth = 4;

	// System clock cycles per half period of the serial clock
	// One full sck period takes twice this
	localparam int defSckHalfPeriod = 2;

endpackage

// File: design/dacFramePkg.sv
package dacFramePkg;

	//////////////////////////////
	// Frame geometry
	//////////////////////////////

	// Bits clocked into the converter per transfer
	localparam int frameBits = 32;

	// Field widths of one frame
	localparam int cmdBits = 4;
	localparam int addrBits = 4;
	localparam int valueBits = 12;

	//////////////////////////////
	// Command and address codes
	//////////////////////////////

	// Write and update immediately, the only command acted on
	localparam logic [cmdBits-1:0] cmdWriteUpdate = 4'b0011;

	// Single channels and the broadcast code
	localparam logic [addrBits-1:0] addrA = 4'b0000;
	localparam logic [addrBits-1:0] addrB = 4'b0001;
	localparam logic [addrBits-1:0] addrC = 4'b0010;
	localparam logic [addrBits-1:0] addrD = 4'b0011;
	localparam logic [addrBits-1:0] addrAll = 4'b1111;

	// One frame word, seen either as a shift vector or as fields
	// Field view from the MSB down, padding on both ends
	typedef union packed {
		logic [frameBits-1:0] raw;
		struct packed {
			logic [7:0] dontCareHi;
			logic [cmdBits-1:0] command;
			logic [addrBits-1:0] address;
			logic [valueBits-1:0] value;
			logic [3:0] dontCareLo;
		} fields;
	} dacFrame;

endpackage

// File: design/dacLtc2624Model.sv
`timescale 1ns/1ps

module dacLtc2624Model (
	input logic DAC_CLR,
	input logic reseted,
	input logic spiSck,
	input logic dacCs,
	input logic spiMosi,
	output logic [11:0] channelA,
	output logic [11:0] channelB,
	output logic [11:0] channelC,
	output logic [11:0] channelD,
	output logic frameDone,
	output logic frameError
);

	// One extra bit separates an overrun from exactly frameBits
	localparam int cntWidth = $clog2(dacFramePkg::frameBits) + 1;

	// Registered copies of the serial control lines
	logic sckPrev;
	logic csPrev;

	// Edge strobes
	logic sckRise;
	logic csRise;

	dacFramePkg::dacFrame frameReg;
	logic [cntWidth-1:0] bitCnt;

	// Frame checks
	logic countOk;
	logic addrOk;
	logic cmdOk;
	logic frameOk;

	assign sckRise = spiSck && !sckPrev;
	assign csRise = dacCs && !csPrev;

	//////////////////////////////
	// Serial receiver
	//////////////////////////////

	// CS idles high, so its copy resets high to avoid a false end of frame
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			sckPrev <= 1'b0;
			csPrev <= 1'b1;
		end else begin
			sckPrev <= spiSck;
			csPrev <= dacCs;
		end
	end

	// Bit counter cleared while deselected
	// Saturates one past a full frame, so long bursts cannot wrap back to 32
	always_ff @(posedge DAC_CLR) begin
		if (reseted || dacCs) begin
			bitCnt <= '0;
		end else if (sckRise && bitCnt != cntWidth'(dacFramePkg::frameBits + 1)) begin
			bitCnt <= bitCnt + cntWidth'(1);
		end
	end

	// Data enters at the LSB, so the first bit ends up at the MSB
	always_ff @(posedge DAC_CLR) begin
		if (sckRise && !dacCs) begin
			frameReg.raw <= {frameReg.raw[dacFramePkg::frameBits-2:0], spiMosi};
		end
	end

	//////////////////////////////
	// Frame check
	//////////////////////////////

	assign countOk = (bitCnt == cntWidth'(dacFramePkg::frameBits));
	assign cmdOk = (frameReg.fields.command == dacFramePkg::cmdWriteUpdate);

	always_comb begin
		case (frameReg.fields.address)
			dacFramePkg::addrA,
			dacFramePkg::addrB,
			dacFramePkg::addrC,
			dacFramePkg::addrD,
			dacFramePkg::addrAll: addrOk = 1'b1;
			default: addrOk = 1'b0;
		endcase
	end

	assign frameOk = countOk && addrOk && cmdOk;

	// Status pulses and channel update all land on the cycle after CS rises
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			frameDone <= 1'b0;
			frameError <= 1'b0;
			channelA <= '0;
			channelB <= '0;
			channelC <= '0;
			channelD <= '0;
		end else begin
			frameDone <= csRise;
			frameError <= csRise && !frameOk;
			if (csRise && frameOk) begin
				// Broadcast writes every channel
				if (frameReg.fields.address == dacFramePkg::addrA ||
						frameReg.fields.address == dacFramePkg::addrAll) begin
					channelA <= frameReg.fields.value;
				end
				if (frameReg.fields.address == dacFramePkg::addrB ||
						frameReg.fields.address == dacFramePkg::addrAll) begin
					channelB <= frameReg.fields.value;
				end
				if (frameReg.fields.address == dacFramePkg::addrC ||
						frameReg.fields.address == dacFramePkg::addrAll) begin
					channelC <= frameReg.fields.value;
				end
				if (frameReg.fields.address == dacFramePkg::addrD ||
						frameReg.fields.address == dacFramePkg::addrAll) begin
					channelD <= frameReg.fields.value;
				end
			end
		end
	end

endmodule

// File: design/dacSpiSerializer.sv
`timescale 1ns/1ps

module dacSpiSerializer #(
	parameter int sckHalfPeriod = 2
) (
	input logic DAC_CLR,
	input logic reseted,
	output logic pop,
	input dacFramePkg::dacFrame popFrame,
	input logic empty,
	output logic spiSck,
	output logic dacCs,
	output logic spiMosi
);

	// Divider also times the gap, so it must reach twice the half period
	localparam int divWidth = $clog2(2 * sckHalfPeriod);
	localparam int bitWidth = $clog2(dacFramePkg::frameBits);

	// State encodings
	localparam logic [1:0] stateIdle = 2'd0;
	localparam logic [1:0] stateSelect = 2'd1;
	localparam logic [1:0] stateShift = 2'd2;
	localparam logic [1:0] stateGap = 2'd3;

	logic [1:0] state;
	logic [divWidth-1:0] divCnt;
	logic [bitWidth-1:0] bitCnt;
	logic sckReg;
	logic csReg;
	dacFramePkg::dacFrame shiftReg;

	// Divider and bit position terminal counts
	logic halfDone;
	logic gapDone;
	logic lastBit;

	assign halfDone = (divCnt == divWidth'(sckHalfPeriod - 1));
	assign gapDone = (divCnt == divWidth'(2 * sckHalfPeriod - 1));
	assign lastBit = (bitCnt == bitWidth'(dacFramePkg::frameBits - 1));

	// Take the head frame on the first idle cycle with data
	assign pop = (state == stateIdle) && !empty;

	//////////////////////////////
	// Transfer FSM
	//////////////////////////////

	// Select is the first low half period, so MOSI settles before the first rise
	// Shift runs the remaining 63 half periods, then CS rises with sck low
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			state <= stateIdle;
			divCnt <= '0;
			bitCnt <= '0;
			sckReg <= 1'b0;
			csReg <= 1'b1;
		end else begin
			case (state)
				stateIdle: begin
					if (!empty) begin
						state <= stateSelect;
						csReg <= 1'b0;
						divCnt <= '0;
						bitCnt <= '0;
					end
				end
				stateSelect: begin
					if (halfDone) begin
						divCnt <= '0;
						sckReg <= 1'b1;
						state <= stateShift;
					end else begin
						divCnt <= divCnt + divWidth'(1);
					end
				end
				stateShift: begin
					if (halfDone) begin
						divCnt <= '0;
						if (!sckReg) begin
							sckReg <= 1'b1;
						end else if (lastBit) begin
							// End of the high phase of bit 0
							sckReg <= 1'b0;
							csReg <= 1'b1;
							state <= stateGap;
						end else begin
							sckReg <= 1'b0;
							bitCnt <= bitCnt + bitWidth'(1);
						end
					end else begin
						divCnt <= divCnt + divWidth'(1);
					end
				end
				default: begin
					// Minimum CS high time between frames
					if (gapDone) begin
						divCnt <= '0;
						state <= stateIdle;
					end else begin
						divCnt <= divCnt + divWidth'(1);
					end
				end
			endcase
		end
	end

	// Shift register, loaded on pop and moved on each falling sck
	always_ff @(posedge DAC_CLR) begin
		if (pop) begin
			shiftReg <= popFrame;
		end else if (state == stateShift && halfDone && sckReg && !lastBit) begin
			shiftReg.raw <= {shiftReg.raw[dacFramePkg::frameBits-2:0], 1'b0};
		end
	end

	assign spiSck = sckReg;
	assign dacCs = csReg;
	// Line rests low outside a transfer
	assign spiMosi = csReg ? 1'b0 : shiftReg.raw[dacFramePkg::frameBits-1];

endmodule

// File: design/dacSubsystem.sv
`timescale 1ns/1ps

module dacSubsystem #(
	parameter int fifoDepth = dacCtrlPkg::defFifoDepth,
	parameter int sckHalfPeriod = dacCtrlPkg::defSckHalfPeriod
) (
	input logic DAC_CLR,
	input logic reseted,
	input logic writeStrobe,
	input logic [3:0] writeAddress,
	input logic [3:0] writeCommand,
	input logic [11:0] writeValue,
	output logic busy,
	output logic spiSck,
	output logic dacCs,
	output logic spiMosi,
	output logic [11:0] channelA,
	output logic [11:0] channelB,
	output logic [11:0] channelC,
	output logic [11:0] channelD,
	output logic frameDone,
	output logic frameError
);

	//////////////////////////////
	// Internal links
	//////////////////////////////

	// Builder to FIFO
	logic push;
	logic full;
	dacFramePkg::dacFrame pushFrame;

	// FIFO to serializer
	logic pop;
	logic empty;
	dacFramePkg::dacFrame popFrame;

	// Producer of frames from host strobes
	dacCommandBuilder builder (
		.DAC_CLR(DAC_CLR),
		.reseted(reseted),
		.writeStrobe(writeStrobe),
		.writeAddress(writeAddress),
		.writeCommand(writeCommand),
		.writeValue(writeValue),
		.busy(busy),
		.push(push),
		.pushFrame(pushFrame),
		.full(full)
	);

	// Frame buffer
	dacWordFifo #(
		.fifoDepth(fifoDepth)
	) fifo (
		.DAC_CLR(DAC_CLR),
		.reseted(reseted),
		.push(push),
		.pushFrame(pushFrame),
		.full(full),
		.pop(pop),
		.popFrame(popFrame),
		.empty(empty)
	);

	// SPI master
	dacSpiSerializer #(
		.sckHalfPeriod(sckHalfPeriod)
	) serializer (
		.DAC_CLR(DAC_CLR),
		.reseted(reseted),
		.pop(pop),
		.popFrame(popFrame),
		.empty(empty),
		.spiSck(spiSck),
		.dacCs(dacCs),
		.spiMosi(spiMosi)
	);

	// Converter model on the same serial lines that leave the block
	dacLtc2624Model dac (
		.DAC_CLR(DAC_CLR),
		.reseted(reseted),
		.spiSck(spiSck),
		.dacCs(dacCs),
		.spiMosi(spiMosi),
		.channelA(channelA),
		.channelB(channelB),
		.channelC(channelC),
		.channelD(channelD),
		.frameDone(frameDone),
		.frameError(frameError)
	);

endmodule

// File: design/dacWordFifo.sv
`timescale 1ns/1ps

module dacWordFifo #(
	parameter int fifoDepth = 4
) (
	input logic DAC_CLR,
	input logic reseted,
	input logic push,
	input dacFramePkg::dacFrame pushFrame,
	output logic full,
	input logic pop,
	output dacFramePkg::dacFrame popFrame,
	output logic empty
);

	// Pointer and occupancy widths
	localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int cntWidth = $clog2(fifoDepth + 1);

	// Frame storage
	dacFramePkg::dacFrame mem [fifoDepth];

	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;

	// Requests that can actually be served
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	// Pointers wrap at fifoDepth so any depth works
	always_ff @(posedge DAC_CLR) begin
		if (reseted) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == ptrWidth'(fifoDepth - 1)) ? '0 : wrPtr + ptrWidth'(1);
			end
			if (doPop) begin
				rdPtr <= (rdPtr == ptrWidth'(fifoDepth - 1)) ? '0 : rdPtr + ptrWidth'(1);
			end
			// Simultaneous push and pop leaves count unchanged
			case ({doPush, doPop})
				2'b10: count <= count + cntWidth'(1);
				2'b01: count <= count - cntWidth'(1);
				default: count <= count;
			endcase
		end
	end

	// Storage write
	always_ff @(posedge DAC_CLR) begin
		if (doPush) begin
			mem[wrPtr] <= pushFrame;
		end
	end

	// Head word shown without a read cycle
	assign popFrame = mem[rdPtr];

	assign full = (count == cntWidth'(fifoDepth));
	assign empty = (count == '0);

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the DAC subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module dacSubsystemTb -o dacSim

# Assertion errors are counted by the testbench, so let the run continue past them
./obj_dir/dacSim +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: verif/dacSubsystemChecker.sv
`timescale 1ns/1ps

module dacSubsystemChecker (
	input logic DAC_CLR,
	input logic reseted,
	input logic writeStrobe,
	input logic [3:0] writeAddress,
	input logic [3:0] writeCommand,
	input logic [11:0] writeValue,
	input logic expectError,
	input logic busy,
	input logic spiSck,
	input logic dacCs,
	input logic spiMosi,
	input logic frameDone,
	input logic frameError,
	input logic [11:0] channelA,
	input logic [11:0] channelB,
	input logic [11:0] channelC,
	input logic [11:0] channelD,
	output int passCount,
	output int failCount,
	output int doneCount,
	output logic stallSeen
);

	// Accepted writes in order, packed as {expectError, command, address, value}
	logic [20:0] pendingQ[$];

	// Predicted converter outputs
	logic [11:0] predA;
	logic [11:0] predB;
	logic [11:0] predC;
	logic [11:0] predD;

	logic busyPrev;
	logic resetChecked;

	// Only write-and-update to a known address changes a channel
	function automatic logic writeTakesEffect(input logic [3:0] addr, input logic [3:0] cmd);
		logic addrKnown;
		addrKnown = (addr == dacFramePkg::addrA) || (addr == dacFramePkg::addrB) ||
			(addr == dacFramePkg::addrC) || (addr == dacFramePkg::addrD) ||
			(addr == dacFramePkg::addrAll);
		return addrKnown && (cmd == dacFramePkg::cmdWriteUpdate);
	endfunction

	function automatic logic sameValue(input string what, input logic [11:0] got,
			input logic [11:0] want);
		if (got !== want) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic tally(input logic ok);
		if (ok) begin
			passCount = passCount + 1;
		end else begin
			failCount = failCount + 1;
		end
	endtask

	//////////////////////////////
	// Per test checks
	//////////////////////////////

	// Test 0, outputs straight out of reset
	task automatic checkResetState();
		logic ok;
		ok = 1'b1;
		ok = ok & sameValue("dacCs", {11'b0, dacCs}, 12'h001);
		ok = ok & sameValue("spiSck", {11'b0, spiSck}, 12'h000);
		ok = ok & sameValue("spiMosi", {11'b0, spiMosi}, 12'h000);
		ok = ok & sameValue("busy", {11'b0, busy}, 12'h000);
		ok = ok & sameValue("frameDone", {11'b0, frameDone}, 12'h000);
		ok = ok & sameValue("frameError", {11'b0, frameError}, 12'h000);
		ok = ok & sameValue("channel A", channelA, 12'h000);
		ok = ok & sameValue("channel B", channelB, 12'h000);
		ok = ok & sameValue("channel C", channelC, 12'h000);
		ok = ok & sameValue("channel D", channelD, 12'h000);
		$display("test 0 reset state %s", ok ? "passed" : "failed");
		tally(ok);
	endtask

	// One finished frame against the oldest outstanding write
	task automatic checkFrame();
		logic [3:0] addr;
		logic [3:0] cmd;
		logic [11:0] value;
		logic wantErr;
		logic ok;
		doneCount = doneCount + 1;
		if (pendingQ.size() == 0) begin
			$display("frame %0d finished with no write waiting for it", doneCount);
			failCount = failCount + 1;
		end else begin
			{wantErr, cmd, addr, value} = pendingQ.pop_front();
			if (writeTakesEffect(addr, cmd)) begin
				// Broadcast address reaches every channel
				if (addr == dacFramePkg::addrA || addr == dacFramePkg::addrAll) predA = value;
				if (addr == dacFramePkg::addrB || addr == dacFramePkg::addrAll) predB = value;
				if (addr == dacFramePkg::addrC || addr == dacFramePkg::addrAll) predC = value;
				if (addr == dacFramePkg::addrD || addr == dacFramePkg::addrAll) predD = value;
			end
			ok = 1'b1;
			ok = ok & sameValue("frameError", {11'b0, frameError}, {11'b0, wantErr});
			ok = ok & sameValue("channel A", channelA, predA);
			ok = ok & sameValue("channel B", channelB, predB);
			ok = ok & sameValue("channel C", channelC, predC);
			ok = ok & sameValue("channel D", channelD, predD);
			$display("test %0d addr %h cmd %h value %h %s", doneCount, addr, cmd, value,
				ok ? "passed" : "failed");
			tally(ok);
		end
	endtask

	// Sampled on the falling edge, half a cycle away from every DUT and host change
	always @(negedge DAC_CLR) begin
		if (reseted) begin
			pendingQ.delete();
			passCount = 0;
			failCount = 0;
			doneCount = 0;
			predA = '0;
			predB = '0;
			predC = '0;
			predD = '0;
			busyPrev = 1'b0;
			stallSeen = 1'b0;
			resetChecked = 1'b0;
		end else begin
			if (!resetChecked) begin
				checkResetState();
				resetChecked = 1'b1;
			end
			// A normal write keeps busy up for one cycle, longer means a full FIFO
			if (busy && busyPrev) begin
				stallSeen = 1'b1;
			end
			busyPrev = busy;
			if (writeStrobe && !busy) begin
				pendingQ.push_back({expectError, writeCommand, writeAddress, writeValue});
			end
			if (frameDone) begin
				checkFrame();
			end
		end
	end

endmodule

// File: verif/dacSubsystemTb.sv
`timescale 1ns/1ps

module dacSubsystemTb;

	localparam int fifoDepth = dacCtrlPkg::defFifoDepth;
	localparam int sckHalfPeriod = dacCtrlPkg::defSckHalfPeriod;
	localparam int resetCycles = 10;

	// Directed entries first, then a burst long enough to fill the FIFO
	localparam int directedCount = 9;
	localparam int burstLength = fifoDepth + 4;
	localparam int numEntries = directedCount + burstLength;

	// Twice the worst frame time per entry
	localparam int cycleLimit = resetCycles + numEntries * (64 * sckHalfPeriod + 16) * 2;

	logic DAC_CLR;
	logic reseted;
	logic writeStrobe;
	logic [3:0] writeAddress;
	logic [3:0] writeCommand;
	logic [11:0] writeValue;
	logic expectError;
	logic busy;
	logic spiSck;
	logic dacCs;
	logic spiMosi;
	logic [11:0] channelA;
	logic [11:0] channelB;
	logic [11:0] channelC;
	logic [11:0] channelD;
	logic frameDone;
	logic frameError;

	int passCount;
	int failCount;
	int doneCount;
	logic stallSeen;

	// Stimulus table, one column per field
	logic [3:0] tabAddr[$];
	logic [3:0] tabCmd[$];
	logic [11:0] tabValue[$];
	logic tabErr[$];

	integer seed;
	int idx;
	int extraFails;
	int assertFails;
	int cycleCount = 0;

	dacSubsystem #(
		.fifoDepth(fifoDepth),
		.sckHalfPeriod(sckHalfPeriod)
	) uut (
		.DAC_CLR(DAC_CLR),
		.reseted(reseted),
		.writeStrobe(writeStrobe),
		.writeAddress(writeAddress),
		.writeCommand(writeCommand),
		.writeValue(writeValue),
		.busy(busy),
		.spiSck(spiSck),
		.dacCs(dacCs),
		.spiMosi(spiMosi),
		.channelA(channelA),
		.channelB(channelB),
		.channelC(channelC),
		.channelD(channelD),
		.frameDone(frameDone),
		.frameError(frameError)
	);

	dacSubsystemChecker scoreboard (
		.DAC_CLR(DAC_CLR),
		.reseted(reseted),
		.writeStrobe(writeStrobe),
		.writeAddress(writeAddress),
		.writeCommand(writeCommand),
		.writeValue(writeValue),
		.expectError(expectError),
		.busy(busy),
		.spiSck(spiSck),
		.dacCs(dacCs),
		.spiMosi(spiMosi),
		.frameDone(frameDone),
		.frameError(frameError),
		.channelA(channelA),
		.channelB(channelB),
		.channelC(channelC),
		.channelD(channelD),
		.passCount(passCount),
		.failCount(failCount),
		.doneCount(doneCount),
		.stallSeen(stallSeen)
	);

	initial begin
		DAC_CLR = 1'b0;
		forever begin
			#5 DAC_CLR = ~DAC_CLR;
		end
	end

	// Run limit
	always @(posedge DAC_CLR) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout: only %0d of %0d frames finished", doneCount, numEntries);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic addEntry(input logic [3:0] addr, input logic [3:0] cmd,
			input logic [11:0] value, input logic err);
		tabAddr.push_back(addr);
		tabCmd.push_back(cmd);
		tabValue.push_back(value);
		tabErr.push_back(err);
	endtask

	task automatic buildTable();
		int i;
		logic [3:0] addr;
		// Single channels, broadcast, then rejects and a follow-up write
		addEntry(dacFramePkg::addrA, dacFramePkg::cmdWriteUpdate, 12'h123, 1'b0);
		addEntry(dacFramePkg::addrB, dacFramePkg::cmdWriteUpdate, 12'h456, 1'b0);
		addEntry(dacFramePkg::addrC, dacFramePkg::cmdWriteUpdate, 12'h789, 1'b0);
		addEntry(dacFramePkg::addrD, dacFramePkg::cmdWriteUpdate, 12'habc, 1'b0);
		addEntry(dacFramePkg::addrAll, dacFramePkg::cmdWriteUpdate, 12'h5a5, 1'b0);
		addEntry(4'd5, dacFramePkg::cmdWriteUpdate, 12'hfff, 1'b1);
		addEntry(dacFramePkg::addrA, 4'b0010, 12'h111, 1'b1);
		addEntry(dacFramePkg::addrB, 4'b0001, 12'h222, 1'b1);
		addEntry(dacFramePkg::addrC, dacFramePkg::cmdWriteUpdate, 12'h0f0, 1'b0);
		// Burst with random values, every fifth one broadcast
		for (i = 0; i < burstLength; i++) begin
			addr = (i % 5 == 4) ? dacFramePkg::addrAll : 4'(i % 4);
			addEntry(addr, dacFramePkg::cmdWriteUpdate, 12'($random(seed)), 1'b0);
		end
	endtask

	// Called 1 ns after a rising edge, leaves 1 ns after the strobe edge
	task automatic applyEntry(input int n);
		while (busy) begin
			@(posedge DAC_CLR);
			#1;
		end
		writeStrobe = 1'b1;
		writeAddress = tabAddr[n];
		writeCommand = tabCmd[n];
		writeValue = tabValue[n];
		expectError = tabErr[n];
		@(posedge DAC_CLR);
		#1;
		writeStrobe = 1'b0;
	endtask

	task automatic waitForDone(input int n);
		while (doneCount < n) begin
			@(posedge DAC_CLR);
			#1;
		end
	endtask

	initial begin
		seed = 57;
		extraFails = 0;
		reseted = 1'b1;
		writeStrobe = 1'b0;
		writeAddress = '0;
		writeCommand = '0;
		writeValue = '0;
		expectError = 1'b0;
		buildTable();
		repeat (resetCycles) @(posedge DAC_CLR);
		#1;
		reseted = 1'b0;
		repeat (2) @(posedge DAC_CLR);
		#1;
		for (idx = 0; idx < directedCount; idx++) begin
			applyEntry(idx);
			// One frame in flight, so busy never stalls here
			waitForDone(idx + 1);
		end
		// Back to back, only busy paces the host
		for (idx = directedCount; idx < numEntries; idx++) begin
			applyEntry(idx);
		end
		waitForDone(numEntries);
		// Room for a stray extra frameDone to show up
		repeat (8 * sckHalfPeriod) @(posedge DAC_CLR);
		#1;
		if (!stallSeen) begin
			$display("the burst never kept busy high, the FIFO did not fill");
			extraFails = extraFails + 1;
		end
		assertFails = uut.serializer.sva.csWidthFails + uut.serializer.sva.mosiFails +
			uut.serializer.sva.sckIdleFails;
		if (assertFails != 0) begin
			$display("%0d serial line assertions failed", assertFails);
		end
		$display("tests passed %0d failed %0d", passCount,
			failCount + extraFails + assertFails);
		if (failCount == 0 && extraFails == 0 && assertFails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: verif/dacSubsystem_sva.sv
`timescale 1ns/1ps

module dacSerializerSva #(
	parameter int sckHalfPeriod = 2
) (
	input logic DAC_CLR,
	input logic reseted,
	input logic spiSck,
	input logic dacCs,
	input logic spiMosi
);

	// Chip select low time of one complete frame
	localparam int csLowCycles = 2 * dacFramePkg::frameBits * sckHalfPeriod;

	// Clock edges seen with CS low in the current frame
	int csLowCount;

	// Failure tallies read by the testbench top
	int csWidthFails = 0;
	int mosiFails = 0;
	int sckIdleFails = 0;

	always_ff @(posedge DAC_CLR) begin
		if (reseted || dacCs) begin
			csLowCount <= 0;
		end else begin
			csLowCount <= csLowCount + 1;
		end
	end

	//////////////////////////////
	// Serial line rules
	//////////////////////////////

	// CS must rise after exactly one frame worth of half periods
	csWidth: assert property (@(posedge DAC_CLR) disable iff (reseted)
		$rose(dacCs) |-> csLowCount == csLowCycles)
		else begin
			$error("dacCs low time differs from one frame");
			csWidthFails++;
		end

	// Data may only move while sck is low
	mosiStable: assert property (@(posedge DAC_CLR) disable iff (reseted)
		spiSck |-> $stable(spiMosi))
		else begin
			$error("spiMosi changed while spiSck was high");
			mosiFails++;
		end

	// No clock pulses outside a transfer
	sckIdle: assert property (@(posedge DAC_CLR) disable iff (reseted)
		dacCs |-> !spiSck)
		else begin
			$error("spiSck high while dacCs was high");
			sckIdleFails++;
		end

endmodule

bind dacSpiSerializer dacSerializerSva #(
	.sckHalfPeriod(sckHalfPeriod)
) sva (
	.DAC_CLR(DAC_CLR),
	.reseted(reseted),
	.spiSck(spiSck),
	.dacCs(dacCs),
	.spiMosi(spiMosi)
);
